// File: logic/asg_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared widths, register map and types for the signal generator
// samples and gain are two's complement, gain has 14 fraction bits
// table pointer is unsigned fixed point, 10 integer + 16 fraction
//////////////////////////////////////////////////////////////////////

package asg_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  localparam int unsigned sample_w  = 14;              // DAC sized
  localparam int unsigned tbl_aw    = 10;              // 1024 entries
  localparam int unsigned frac_w    = 16;
  localparam int unsigned ptr_w     = tbl_aw + frac_w;
  localparam int unsigned gain_w    = 16;
  localparam int unsigned gain_frac = 14;              // 0x4000 is unity
  localparam int unsigned trg_w     = 4;
  localparam int unsigned reg_aw    = 7;
  localparam int unsigned reg_dw    = 32;

  // register map
  localparam logic [reg_aw-1:0] addr_ctl  = 7'h00; // control / status
  localparam logic [reg_aw-1:0] addr_trg  = 7'h10; // ext trigger mask
  localparam logic [reg_aw-1:0] addr_siz  = 7'h20;
  localparam logic [reg_aw-1:0] addr_off  = 7'h24;
  localparam logic [reg_aw-1:0] addr_ste  = 7'h28;
  localparam logic [reg_aw-1:0] addr_mode = 7'h30; // bit0 one-shot
  localparam logic [reg_aw-1:0] addr_gain = 7'h48;
  localparam logic [reg_aw-1:0] addr_sum  = 7'h4c;

  //////////////////////////////////////////////////////////////////////
  // types
  typedef logic signed [sample_w-1:0] sample_t;
  typedef logic        [tbl_aw-1:0]   tbl_addr_t;
  typedef logic        [ptr_w-1:0]    ptr_t;
  typedef logic signed [gain_w-1:0]   gain_t;
  typedef logic        [trg_w-1:0]    trg_t;

  typedef struct packed {
    logic              wen;
    logic              ren;
    logic [reg_aw-1:0] addr;
    logic [reg_dw-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic              ack;   // one cycle after wen/ren
    logic [reg_dw-1:0] rdata;
  } reg_rsp_t;

  typedef struct packed {logic wen; tbl_addr_t addr; sample_t wdata;} tbl_req_t;
  typedef struct packed {logic vld; sample_t data;} sample_out_t;
  typedef struct packed {ptr_t siz; ptr_t off; ptr_t ste;} gen_cfg_t;
  typedef struct packed {gain_t gain; sample_t sum;} lin_cfg_t;

  typedef enum logic [1:0] {st_idle, st_armed, st_run} gen_state_t;

endpackage

// File: logic/asg_ctrl.sv
//////////////////////////////////////////////////////////////////////
// register file, bus decode and generator FSM
// bus ack is a fixed one cycle after request, no back-pressure
// ctl writes act on the state one cycle after the write cycle
// ld is combinational, same cycle as the trigger while armed
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_ctrl (
  input  logic                bus_reg,
  input  logic                arst_n,
  input  asg_pkg::reg_req_t   reg_req,
  input  asg_pkg::trg_t       evn_ext,
  input  logic                wrap,     // pointer passed size
  output asg_pkg::reg_rsp_t   reg_rsp,
  output asg_pkg::gen_cfg_t   gen_cfg,
  output asg_pkg::lin_cfg_t   lin_cfg,
  output logic                ld,       // load offset
  output logic                run,      // advance pointer
  output logic                evn_per,
  output logic                evn_lst,
  output logic                sts_run
);

  asg_pkg::trg_t              cfg_trg;  // ext trigger mask
  logic                       cfg_mode; // one-shot when set
  logic                       ctl_wr;
  logic                       ctl_clr;
  logic                       ctl_str;
  logic                       ctl_stp;
  logic                       ctl_trg;
  logic                       ext_trg;
  asg_pkg::gen_state_t        state;
  asg_pkg::gen_state_t        state_nxt;
  logic                       ack_q;
  logic [asg_pkg::reg_dw-1:0] rdata_q;
  logic [asg_pkg::reg_dw-1:0] rd_mux;

  //////////////////////////////////////////////////////////////////////
  // bus side

  assign ctl_wr  = reg_req.wen && (reg_req.addr == asg_pkg::addr_ctl);
  assign ctl_clr = ctl_wr & reg_req.wdata[0];
  assign ctl_str = ctl_wr & reg_req.wdata[1];
  assign ctl_stp = ctl_wr & reg_req.wdata[2];
  assign ctl_trg = ctl_wr & reg_req.wdata[3]; // software trigger
  assign ext_trg = |(evn_ext & cfg_trg);

  always_ff @(posedge bus_reg or negedge arst_n) begin
    if (!arst_n) begin
      ack_q    <= 1'b0;
      cfg_trg  <= '0;
      cfg_mode <= 1'b0;
      gen_cfg  <= '0;
      lin_cfg  <= '0;
    end else begin
      ack_q <= reg_req.wen | reg_req.ren;
      if (reg_req.wen) begin
        case (reg_req.addr)
          asg_pkg::addr_trg:  cfg_trg      <= reg_req.wdata[asg_pkg::trg_w-1:0];
          asg_pkg::addr_siz:  gen_cfg.siz  <= reg_req.wdata[asg_pkg::ptr_w-1:0];
          asg_pkg::addr_off:  gen_cfg.off  <= reg_req.wdata[asg_pkg::ptr_w-1:0];
          asg_pkg::addr_ste:  gen_cfg.ste  <= reg_req.wdata[asg_pkg::ptr_w-1:0];
          asg_pkg::addr_mode: cfg_mode     <= reg_req.wdata[0];
          asg_pkg::addr_gain: lin_cfg.gain <= reg_req.wdata[asg_pkg::gain_w-1:0];
          asg_pkg::addr_sum:  lin_cfg.sum  <= reg_req.wdata[asg_pkg::sample_w-1:0];
          default: ;                          // ctl handled as pulses
        endcase
      end
    end
  end

  // read mux, fields zero extended
  always_comb begin
    rd_mux = '0;
    case (reg_req.addr)
      asg_pkg::addr_ctl:  rd_mux[1:0] = {state == asg_pkg::st_armed, sts_run};
      asg_pkg::addr_trg:  rd_mux[asg_pkg::trg_w-1:0]    = cfg_trg;
      asg_pkg::addr_siz:  rd_mux[asg_pkg::ptr_w-1:0]    = gen_cfg.siz;
      asg_pkg::addr_off:  rd_mux[asg_pkg::ptr_w-1:0]    = gen_cfg.off;
      asg_pkg::addr_ste:  rd_mux[asg_pkg::ptr_w-1:0]    = gen_cfg.ste;
      asg_pkg::addr_mode: rd_mux[0]                     = cfg_mode;
      asg_pkg::addr_gain: rd_mux[asg_pkg::gain_w-1:0]   = lin_cfg.gain;
      asg_pkg::addr_sum:  rd_mux[asg_pkg::sample_w-1:0] = lin_cfg.sum;
      default:            rd_mux = '0;        // unmapped
    endcase
  end

  always_ff @(posedge bus_reg) begin
    if (reg_req.ren) rdata_q <= rd_mux;       // lands with ack
  end

  assign reg_rsp = '{ack: ack_q, rdata: rdata_q};

  //////////////////////////////////////////////////////////////////////
  // generator FSM

  always_comb begin
    state_nxt = state;
    ld        = 1'b0;
    case (state)
      asg_pkg::st_idle:  if (ctl_str) state_nxt = asg_pkg::st_armed;
      asg_pkg::st_armed: begin
        if (ctl_trg | ext_trg) begin
          ld        = 1'b1;                   // offset load, run follows
          state_nxt = asg_pkg::st_run;
        end
      end
      asg_pkg::st_run:   if (wrap && cfg_mode) state_nxt = asg_pkg::st_idle;
      default:           state_nxt = asg_pkg::st_idle;
    endcase
    if (ctl_clr | ctl_stp) state_nxt = asg_pkg::st_idle; // from anywhere
  end

  always_ff @(posedge bus_reg or negedge arst_n) begin
    if (!arst_n) begin
      state   <= asg_pkg::st_idle;
      evn_per <= 1'b0;
      evn_lst <= 1'b0;
    end else begin
      state   <= state_nxt;
      evn_per <= wrap;                        // one cycle behind wrap
      evn_lst <= wrap & cfg_mode;             // only pass in one-shot
    end
  end

  assign run     = (state == asg_pkg::st_run);
  assign sts_run = run;

  // pointer only flags wrap while running
  a_wrap_run: assert property (@(posedge bus_reg) disable iff (!arst_n)
    wrap |-> run);

endmodule

// File: logic/asg_table.sv
//////////////////////////////////////////////////////////////////////
// 1024 x 14 waveform memory, single clock
// CPU write completes in the cycle it is presented, no ack
// read data registered, valid is rd_en delayed one cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_table (
  input  logic                   bus_reg,
  input  logic                   arst_n,   // valid flop only
  input  asg_pkg::tbl_req_t      tbl_req,
  input  asg_pkg::tbl_addr_t     rd_addr,
  input  logic                   rd_en,
  output asg_pkg::sample_out_t   rd
);

  asg_pkg::sample_t mem [0:(1<<asg_pkg::tbl_aw)-1];
  asg_pkg::sample_t rd_data;
  logic             rd_vld;

  // cpu write port
  always_ff @(posedge bus_reg) begin
    if (tbl_req.wen) mem[tbl_req.addr] <= tbl_req.wdata;
  end

  // sync read port
  always_ff @(posedge bus_reg) begin
    if (rd_en) rd_data <= mem[rd_addr];
  end

  always_ff @(posedge bus_reg or negedge arst_n) begin
    if (!arst_n) rd_vld <= 1'b0;
    else         rd_vld <= rd_en;
  end

  assign rd = '{vld: rd_vld, data: rd_data};

endmodule

// File: logic/asg_phase.sv
//////////////////////////////////////////////////////////////////////
// fixed point table pointer, 10.16 unsigned
// wraps by subtracting size, so step should stay below size
// wrap is combinational, high in the cycle the pointer passes size
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_phase (
  input  logic                 bus_reg,
  input  logic                 arst_n,
  input  asg_pkg::gen_cfg_t    gen_cfg,
  input  logic                 ld,       // load offset
  input  logic                 run,      // advance by step
  output asg_pkg::tbl_addr_t   rd_addr,
  output logic                 rd_en,
  output logic                 wrap
);

  asg_pkg::ptr_t            ptr;
  asg_pkg::ptr_t            ptr_nxt;
  logic [asg_pkg::ptr_w:0]  ptr_sum;  // extra carry bit
  logic [asg_pkg::ptr_w:0]  ptr_dif;

  //////////////////////////////////////////////////////////////////////
  // next pointer

  assign ptr_sum = {1'b0, ptr} + {1'b0, gen_cfg.ste};
  assign ptr_dif = ptr_sum - {1'b0, gen_cfg.siz};

  // reached or passed size, fold back
  assign wrap    = run && (ptr_sum >= {1'b0, gen_cfg.siz});
  assign ptr_nxt = wrap ? ptr_dif[asg_pkg::ptr_w-1:0]
                        : ptr_sum[asg_pkg::ptr_w-1:0];

  always_ff @(posedge bus_reg or negedge arst_n) begin
    if (!arst_n) begin
      ptr <= '0;
    end else if (ld) begin
      ptr <= gen_cfg.off;                 // phase start
    end else if (run) begin
      ptr <= ptr_nxt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // table read

  assign rd_addr = ptr[asg_pkg::ptr_w-1 -: asg_pkg::tbl_aw]; // integer part
  assign rd_en   = run;

  // FSM only pulses ld while armed
  a_ld_run: assert property (@(posedge bus_reg) disable iff (!arst_n)
    !(ld && run));

endmodule

// File: logic/asg_lin.sv
//////////////////////////////////////////////////////////////////////
// gain and offset on the sample stream, one register stage
// out = sat(((x * gain) >>> 14) + sum), clipped to -8192..8191
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_lin (
  input  logic                   bus_reg,
  input  logic                   arst_n,
  input  asg_pkg::sample_out_t   rd,
  input  asg_pkg::lin_cfg_t      lin_cfg,
  output asg_pkg::sample_out_t   smp
);

  logic signed [asg_pkg::sample_w+asg_pkg::gain_w-1:0] prod;
  logic signed [asg_pkg::sample_w+asg_pkg::gain_w-1:0] scaled;
  logic signed [asg_pkg::sample_w+asg_pkg::gain_w:0]   acc;    // one bit headroom
  logic                                                ovf;
  asg_pkg::sample_t                                    sat;
  asg_pkg::sample_t                                    data_q;
  logic                                                vld_q;

  // multiply, drop gain fraction
  assign prod   = $signed(rd.data) * $signed(lin_cfg.gain);
  assign scaled = prod >>> asg_pkg::gain_frac;
  assign acc    = scaled + $signed(lin_cfg.sum);

  // upper bits must all equal the sign bit
  assign ovf = !((&acc[$high(acc):asg_pkg::sample_w-1]) ||
                 !(|acc[$high(acc):asg_pkg::sample_w-1]));
  assign sat = ovf ? {acc[$high(acc)], {(asg_pkg::sample_w-1){~acc[$high(acc)]}}}
                   : acc[asg_pkg::sample_w-1:0];

  always_ff @(posedge bus_reg) begin
    if (rd.vld) data_q <= sat;          // hold between samples
  end

  always_ff @(posedge bus_reg or negedge arst_n) begin
    if (!arst_n) vld_q <= 1'b0;
    else         vld_q <= rd.vld;
  end

  assign smp = '{vld: vld_q, data: data_q};

  // table entries read out must have been written
  a_rd_known: assert property (@(posedge bus_reg) disable iff (!arst_n)
    rd.vld |-> !$isunknown(rd.data));

endmodule

// File: logic/asg_top.sv
//////////////////////////////////////////////////////////////////////
// single channel arbitrary signal generator
// pointer to smp.vld latency is 2 cycles, samples drain after stop
// output has no back-pressure, one valid pulse per sample
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_top (
  input  logic                   bus_reg,
  input  logic                   arst_n,
  input  asg_pkg::reg_req_t      reg_req,  // register bus
  input  asg_pkg::tbl_req_t      tbl_req,  // table write
  input  asg_pkg::trg_t          evn_ext,  // external triggers
  output asg_pkg::reg_rsp_t      reg_rsp,
  output asg_pkg::sample_out_t   smp,
  output logic                   evn_per,
  output logic                   evn_lst,
  output logic                   sts_run
);

  asg_pkg::gen_cfg_t     gen_cfg;
  asg_pkg::lin_cfg_t     lin_cfg;
  logic                  ld;
  logic                  run;
  logic                  wrap;
  asg_pkg::tbl_addr_t    rd_addr;
  logic                  rd_en;
  asg_pkg::sample_out_t  rd;       // table read stream

  //////////////////////////////////////////////////////////////////////
  // control
  asg_ctrl i_ctrl (
    .bus_reg (bus_reg), .arst_n  (arst_n),
    .reg_req (reg_req), .evn_ext (evn_ext), .wrap    (wrap),
    .reg_rsp (reg_rsp), .gen_cfg (gen_cfg), .lin_cfg (lin_cfg),
    .ld      (ld),      .run     (run),
    .evn_per (evn_per), .evn_lst (evn_lst), .sts_run (sts_run)
  );

  //////////////////////////////////////////////////////////////////////
  // datapath, pointer -> table -> gain/offset
  asg_phase i_phase (
    .bus_reg (bus_reg), .arst_n  (arst_n), .gen_cfg (gen_cfg),
    .ld      (ld),      .run     (run),
    .rd_addr (rd_addr), .rd_en   (rd_en),  .wrap    (wrap)
  );

  asg_table i_table (
    .bus_reg (bus_reg), .arst_n  (arst_n), .tbl_req (tbl_req),
    .rd_addr (rd_addr), .rd_en   (rd_en),  .rd      (rd)
  );

  asg_lin i_lin (
    .bus_reg (bus_reg), .arst_n  (arst_n),
    .rd      (rd),      .lin_cfg (lin_cfg), .smp    (smp)
  );

endmodule

// File: verification/tb_asg.sv
//////////////////////////////////////////////////////////////////////
// testbench for asg_top, commands and expected values from golden file
// samples and event pulses are collected by a monitor, no fixed latency
// a stop leaves samples in flight, the golden file drains them
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_asg;

  localparam int gold_len = 1024;            // words, 3 per record
  localparam int wait_max = 200;             // cycles per wait

  logic                 bus_reg;
  logic                 arst_n;
  asg_pkg::reg_req_t    reg_req;
  asg_pkg::tbl_req_t    tbl_req;
  asg_pkg::trg_t        evn_ext;
  asg_pkg::reg_rsp_t    reg_rsp;
  asg_pkg::sample_out_t smp;
  logic                 evn_per;
  logic                 evn_lst;
  logic                 sts_run;

  logic [31:0]          gold [0:gold_len-1]; // op, arg, value
  asg_pkg::sample_t     smp_q [$];           // samples not yet checked
  int                   per_cnt;
  int                   lst_cnt;
  int                   err_val;
  int                   err_misc;

  asg_top i_dut (.*);

  initial begin
    bus_reg = 1'b0;
    forever #10 bus_reg = ~bus_reg;          // 20 ns
  end

  // monitor, mid cycle where outputs are settled
  always @(negedge bus_reg) begin
    if (arst_n) begin
      if (smp.vld) smp_q.push_back(smp.data);
      if (evn_per) per_cnt++;
      if (evn_lst) lst_cnt++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reporting

  task automatic log_mismatch(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    err_val++;
    $display("** Error %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
  endtask

  task automatic log_failure(input string msg);
    err_misc++;
    $display("failure at %0t: %s", $time, msg);
  endtask

  function automatic int pending(input int kind);
    return (kind == 0) ? per_cnt : lst_cnt;  // 0 period, 1 last
  endfunction

  //////////////////////////////////////////////////////////////////////
  // bus and stimulus

  // ack must be low in the request cycle and high in the next one
  task automatic reg_access(input logic wr, input logic [6:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp);
    asg_pkg::reg_req_t req;
    req.wen   = wr;
    req.ren   = !wr;
    req.addr  = addr;
    req.wdata = wdata;
    @(posedge bus_reg);
    reg_req <= req;
    @(negedge bus_reg);
    assert (reg_rsp.ack === 1'b0) else log_mismatch("reg_rsp.ack", reg_rsp.ack, 0);
    @(posedge bus_reg);
    reg_req <= '0;
    @(negedge bus_reg);
    assert (reg_rsp.ack === 1'b1) else log_mismatch("reg_rsp.ack", reg_rsp.ack, 1);
    if (!wr) begin
      assert (reg_rsp.rdata === exp) else log_mismatch("reg_rsp.rdata", reg_rsp.rdata, exp);
    end
  endtask

  task automatic write_table(input logic [9:0] addr, input logic [13:0] data);
    asg_pkg::tbl_req_t req;
    req.wen   = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    @(posedge bus_reg);
    tbl_req <= req;
    @(posedge bus_reg);
    tbl_req <= '0;
  endtask

  task automatic pulse_ext(input logic [3:0] val);
    @(posedge bus_reg);
    evn_ext <= val;                          // one cycle only
    @(posedge bus_reg);
    evn_ext <= '0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks

  task automatic expect_sample(input logic [13:0] exp);
    int               n;
    asg_pkg::sample_t got;
    n = 0;
    while (smp_q.size() == 0 && n < wait_max) begin
      @(posedge bus_reg);                    // queue only grows at negedge
      n++;
    end
    if (smp_q.size() == 0) begin
      log_failure("no output sample within the timeout");
    end else begin
      got = smp_q.pop_front();
      assert (got === exp) else log_mismatch("smp.data", $unsigned(got), exp);
    end
  endtask

  task automatic expect_event(input int kind);
    int n;
    n = 0;
    if (kind == 2) begin                     // sts_run back low
      while (sts_run !== 1'b0 && n < wait_max) begin
        @(negedge bus_reg);
        n++;
      end
      if (sts_run !== 1'b0) log_failure("sts_run did not return low");
    end else begin
      while (pending(kind) == 0 && n < wait_max) begin
        @(posedge bus_reg);
        n++;
      end
      if (pending(kind) == 0) log_failure("expected event pulse did not arrive");
      else if (kind == 0) per_cnt--;
      else lst_cnt--;
    end
  endtask

  // wait for smp.vld to stay low, then drop what is left over
  task automatic drain_output();
    int n;
    int quiet;
    n     = 0;
    quiet = 0;
    while (quiet < 4 && n < wait_max) begin
      @(negedge bus_reg);
      quiet = smp.vld ? 0 : quiet + 1;
      n++;
    end
    if (quiet < 4) log_failure("smp.vld did not cease after stop");
    @(posedge bus_reg);
    smp_q.delete();
    per_cnt = 0;
    lst_cnt = 0;
  endtask

  task automatic check_quiet();
    repeat (16) begin
      @(negedge bus_reg);
      assert (sts_run === 1'b0) else log_mismatch("sts_run", sts_run, 0);
    end
    @(posedge bus_reg);
    assert (smp_q.size() == 0) else log_mismatch("smp.vld count", smp_q.size(), 0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin : main
    int          idx;
    logic [31:0] op;
    logic [31:0] arg;
    logic [31:0] val;
    arst_n   = 1'b0;
    reg_req  = '0;
    tbl_req  = '0;
    evn_ext  = '0;
    err_val  = 0;
    err_misc = 0;
    $readmemh("verification/asg_golden.txt", gold);
    repeat (4) @(posedge bus_reg);
    arst_n <= 1'b1;
    @(negedge bus_reg);
    assert ({reg_rsp.ack, smp.vld, evn_per, evn_lst, sts_run} === 5'b0)
      else log_mismatch("reset outputs", {reg_rsp.ack, smp.vld, evn_per, evn_lst, sts_run}, 0);
    if ($isunknown(gold[0]) || gold[0] == 0) log_failure("golden file is empty or missing");
    idx = 0;
    // op 0 or an unloaded word ends the list
    while (idx + 2 < gold_len && !$isunknown(gold[idx]) && gold[idx] != 0) begin
      op  = gold[idx];
      arg = gold[idx+1];
      val = gold[idx+2];
      case (op)
        1: reg_access(1'b1, arg[6:0], val, '0);
        2: reg_access(1'b0, arg[6:0], '0, val);
        3: write_table(arg[9:0], val[13:0]);
        4: pulse_ext(val[3:0]);
        5: expect_sample(val[13:0]);
        6: expect_event(arg);
        7: drain_output();
        8: check_quiet();
        default: log_failure("unknown command in golden file");
      endcase
      idx += 3;
    end
    $display("errors: %0d value, %0d other", err_val, err_misc);
    if (err_val + err_misc == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: project.f
logic/asg_pkg.sv
logic/asg_ctrl.sv
logic/asg_table.sv
logic/asg_phase.sv
logic/asg_lin.sv
logic/asg_top.sv
verification/tb_asg.sv

// File: verification/asg_golden.txt
// columns: op arg value, hex. op 1 reg write addr data, 2 reg read addr expect,
// 3 table write entry sample, 4 ext trigger, 5 expect sample, 6 event (0 per 1 lst 2 run low),
// 7 drain after stop, 8 no samples and not running, 0 end
// register readback, zero after reset then masked to field width
2 00 0  2 10 0  2 20 0  2 24 0  2 28 0  2 30 0  2 48 0  2 4c 0
1 10 ffffffff  1 20 ffffffff  1 24 ffffffff  1 28 ffffffff
1 30 ffffffff  1 48 ffffffff  1 4c ffffffff
2 10 f  2 20 3ffffff  2 24 3ffffff  2 28 3ffffff
2 30 1  2 48 ffff  2 4c 3fff  2 40 0
// table, 8 entries
3 0 0000  3 1 0100  3 2 0800  3 3 1000
3 4 1fff  3 5 3000  3 6 2000  3 7 3f00
// continuous, size 8.0, step 1.0, unity gain, two wraps
1 20 80000  1 24 0  1 28 10000  1 30 0  1 48 4000  1 4c 0
1 00 2  1 00 8
5 0 0000  5 0 0100  5 0 0800  5 0 1000  5 0 1fff  5 0 3000  5 0 2000  5 0 3f00
5 0 0000  5 0 0100  5 0 0800  5 0 1000  5 0 1fff  5 0 3000  5 0 2000  5 0 3f00
6 0 0  6 0 0  2 00 1  1 00 4  6 2 0  7 0 0
// step 0.5 from offset 2.0, every entry twice, through the wrap
1 24 20000  1 28 8000  1 00 2  1 00 8
5 0 0800  5 0 0800  5 0 1000  5 0 1000  5 0 1fff  5 0 1fff  5 0 3000  5 0 3000
5 0 2000  5 0 2000  5 0 3f00  5 0 3f00  5 0 0000  5 0 0000  5 0 0100  5 0 0100
1 00 4  6 2 0  7 0 0
// gain -2.0, sum 100, clips at 8191 and -8192
1 24 0  1 28 10000  1 48 8000  1 4c 64  1 00 2  1 00 8
5 0 0064  5 0 3e64  5 0 3064  5 0 2064  5 0 2000  5 0 1fff  5 0 1fff  5 0 0264
1 00 4  6 2 0  7 0 0
// one-shot on ext trigger bit 2, bit 1 masked off
1 48 4000  1 4c 0  1 10 4  1 30 1  1 00 2
8 0 0  4 0 2  8 0 0  2 00 2  4 0 4
5 0 0000  5 0 0100  5 0 0800  5 0 1000  5 0 1fff  5 0 3000  5 0 2000  5 0 3f00
6 1 0  6 0 0  6 2 0  8 0 0  2 00 0
// stop during a continuous run
1 30 0  1 00 2  1 00 8
5 0 0000  5 0 0100  5 0 0800  5 0 1000
1 00 4  6 2 0  7 0 0  2 00 0
0 0 0
